// ==== design/line_buf_pkg.sv ====
package line_buf_pkg;

    // Buffer geometry
    localparam int ROWS    = 3;
    localparam int PIX_W   = 8;
    localparam int MAX_ROW = 64;

    // Column address covers MAX_ROW entries
    localparam int ADDR_W  = 6;

    // Nine pixels of 255 need 12 bits
    localparam int SUM_W   = 12;

    typedef logic [PIX_W-1:0]  pixel_t;
    typedef logic [ADDR_W-1:0] col_addr_t;
    typedef logic [SUM_W-1:0]  sum_t;

    // Selects one of the row memories
    typedef logic [$clog2(ROWS)-1:0] row_sel_t;

    // One column, oldest row on top
    typedef struct packed {
        pixel_t top;
        pixel_t mid;
        pixel_t bot;
    } pix_col_t;

    // 3x3 neighbourhood, right is the newest column
    typedef struct packed {
        pix_col_t left;
        pix_col_t centre;
        pix_col_t right;
    } window_t;

    // Read sequencer states
    typedef enum logic {
        SEQ_IDLE,
        SEQ_SCAN
    } seq_state_t;

endpackage

// ==== design/row_ram.sv ====
module row_ram (
    input  logic                   clk,
    input  logic                   rd,
    input  logic                   wr,
    input  line_buf_pkg::pixel_t    wr_data,
    input  line_buf_pkg::col_addr_t addr,
    output line_buf_pkg::pixel_t    rd_data
);

    // One image row
    line_buf_pkg::pixel_t mem [line_buf_pkg::MAX_ROW];

    // Single port, write and registered read share addr
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[addr] <= wr_data;
        end
        if (rd) begin
            rd_data <= mem[addr];
        end
    end

endmodule

// ==== design/line_coupler.sv ====
module line_coupler (
    input  logic                   clk,
    input  logic                   rst,
    input  line_buf_pkg::col_addr_t row_width,
    input  line_buf_pkg::pixel_t    pixel_in,
    input  logic                   pixel_valid,
    input  logic                   rd_en,
    input  line_buf_pkg::col_addr_t rd_addr,
    output line_buf_pkg::pix_col_t  col_out,
    output logic                   col_valid,
    output logic                   full
);

    line_buf_pkg::col_addr_t wr_addr;
    line_buf_pkg::col_addr_t last_col;
    line_buf_pkg::col_addr_t ram_addr;
    line_buf_pkg::row_sel_t  wr_order;
    logic [line_buf_pkg::ROWS-1:0] row_full;
    logic [line_buf_pkg::ROWS-1:0] ram_wr;
    line_buf_pkg::pixel_t    ram_q [line_buf_pkg::ROWS];

    // Memory holding row k positions after the write order
    function automatic line_buf_pkg::row_sel_t row_at(
        input line_buf_pkg::row_sel_t base,
        input int unsigned            k
    );
        int unsigned idx;
        idx = (int'(base) + k) % line_buf_pkg::ROWS;
        return line_buf_pkg::row_sel_t'(idx);
    endfunction

    // A row_width of 0 wraps to a full MAX_ROW row
    assign last_col = row_width - 1'b1;

    // Writes and reads never overlap, so no arbitration
    assign ram_addr = pixel_valid ? wr_addr : rd_addr;

    assign full = &row_full;

    for (genvar i = 0; i < line_buf_pkg::ROWS; i++) begin : g_row
        assign ram_wr[i] = pixel_valid && (wr_order == line_buf_pkg::row_sel_t'(i));

        row_ram u_ram (
            .clk     (clk),
            .rd      (rd_en),
            .wr      (ram_wr[i]),
            .wr_data (pixel_in),
            .addr    (ram_addr),
            .rd_data (ram_q[i])
        );
    end

    // Oldest to newest; wr_order names the oldest row once all are full
    assign col_out.top = ram_q[row_at(wr_order, 0)];
    assign col_out.mid = ram_q[row_at(wr_order, 1)];
    assign col_out.bot = ram_q[row_at(wr_order, 2)];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr   <= '0;
            wr_order  <= '0;
            row_full  <= '0;
            col_valid <= 1'b0;
        end else begin
            if (pixel_valid) begin
                if (wr_addr == last_col) begin
                    // Row complete, move on to the next memory
                    wr_addr            <= '0;
                    row_full[wr_order] <= 1'b1;
                    if (wr_order == line_buf_pkg::row_sel_t'(line_buf_pkg::ROWS - 1)) begin
                        wr_order <= '0;
                    end else begin
                        wr_order <= wr_order + 1'b1;
                    end
                end else begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end

            // Last column read frees the oldest row
            if (rd_en && rd_addr == last_col) begin
                row_full[wr_order] <= 1'b0;
            end

            col_valid <= rd_en;
        end
    end

endmodule

// ==== design/read_sequencer.sv ====
module read_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  line_buf_pkg::col_addr_t row_width,
    input  logic                   full,
    output logic                   rd_en,
    output line_buf_pkg::col_addr_t rd_addr
);

    line_buf_pkg::seq_state_t state;
    line_buf_pkg::col_addr_t  last_col;

    // Wraps to MAX_ROW-1 when row_width is 0
    assign last_col = row_width - 1'b1;

    // Strobe covers the whole scan
    assign rd_en = (state == line_buf_pkg::SEQ_SCAN);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= line_buf_pkg::SEQ_IDLE;
            rd_addr <= '0;
        end else begin
            unique case (state)
                line_buf_pkg::SEQ_IDLE: begin
                    rd_addr <= '0;
                    // Three rows buffered, start a pass
                    if (full) begin
                        state <= line_buf_pkg::SEQ_SCAN;
                    end
                end

                line_buf_pkg::SEQ_SCAN: begin
                    if (rd_addr == last_col) begin
                        // full drops at this same edge
                        state   <= line_buf_pkg::SEQ_IDLE;
                        rd_addr <= '0;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                end

                default: begin
                    state   <= line_buf_pkg::SEQ_IDLE;
                    rd_addr <= '0;
                end
            endcase
        end
    end

endmodule

// ==== design/window_shift.sv ====
module window_shift (
    input  logic                   clk,
    input  logic                   rst,
    input  line_buf_pkg::col_addr_t row_width,
    input  line_buf_pkg::pix_col_t  col_in,
    input  logic                   col_valid,
    output line_buf_pkg::window_t   win,
    output logic                   win_valid
);

    line_buf_pkg::col_addr_t col_cnt;
    line_buf_pkg::col_addr_t last_col;

    assign last_col = row_width - 1'b1;

    // Pixel registers
    always_ff @(posedge clk) begin
        if (col_valid) begin
            win.left   <= win.centre;
            win.centre <= win.right;
            win.right  <= col_in;
        end
    end

    // Column position within the current pass
    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt   <= '0;
            win_valid <= 1'b0;
        end else begin
            // Need two earlier columns of this pass
            win_valid <= col_valid && (col_cnt >= 2);
            if (col_valid) begin
                if (col_cnt == last_col) begin
                    col_cnt <= '0;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/box_filter.sv ====
module box_filter (
    input  logic                  clk,
    input  logic                  rst,
    input  line_buf_pkg::window_t  win,
    input  logic                  win_valid,
    output line_buf_pkg::sum_t     sum_out,
    output logic                  sum_valid
);

    line_buf_pkg::sum_t sum_left;
    line_buf_pkg::sum_t sum_centre;
    line_buf_pkg::sum_t sum_right;
    line_buf_pkg::sum_t sum_all;

    // Vertical sum of one column, widened before the add
    function automatic line_buf_pkg::sum_t col_sum(input line_buf_pkg::pix_col_t c);
        line_buf_pkg::sum_t s;
        s = line_buf_pkg::sum_t'(c.top);
        s = s + line_buf_pkg::sum_t'(c.mid);
        s = s + line_buf_pkg::sum_t'(c.bot);
        return s;
    endfunction

    // Column sums
    assign sum_left   = col_sum(win.left);
    assign sum_centre = col_sum(win.centre);
    assign sum_right  = col_sum(win.right);

    // Total of nine, fits SUM_W without overflow
    assign sum_all = sum_left + sum_centre + sum_right;

    // Result register
    always_ff @(posedge clk) begin
        if (win_valid) begin
            sum_out <= sum_all;
        end
    end

    // Valid trails win_valid by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= win_valid;
        end
    end

endmodule

// ==== design/conv_line_top.sv ====
module conv_line_top (
    input  logic                   clk,
    input  logic                   rst,
    input  line_buf_pkg::col_addr_t row_width,
    input  line_buf_pkg::pixel_t    pixel_in,
    input  logic                   pixel_valid,
    output logic                   full,
    output line_buf_pkg::sum_t      sum_out,
    output logic                   sum_valid
);

    // Read control from the sequencer
    logic                    rd_en;
    line_buf_pkg::col_addr_t rd_addr;

    // Reordered column stream
    line_buf_pkg::pix_col_t  col_out;
    logic                    col_valid;

    // Neighbourhood into the filter
    line_buf_pkg::window_t   win;
    logic                    win_valid;

    line_coupler u_coupler (
        .clk         (clk),
        .rst         (rst),
        .row_width   (row_width),
        .pixel_in    (pixel_in),
        .pixel_valid (pixel_valid),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .col_out     (col_out),
        .col_valid   (col_valid),
        .full        (full)
    );

    read_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .row_width (row_width),
        .full      (full),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr)
    );

    window_shift u_window (
        .clk       (clk),
        .rst       (rst),
        .row_width (row_width),
        .col_in    (col_out),
        .col_valid (col_valid),
        .win       (win),
        .win_valid (win_valid)
    );

    box_filter u_filter (
        .clk       (clk),
        .rst       (rst),
        .win       (win),
        .win_valid (win_valid),
        .sum_out   (sum_out),
        .sum_valid (sum_valid)
    );

endmodule

// ==== test/tb_clock.sv ====
module tb_clock (
    output logic clk
);

    // Half of the 10 unit period
    localparam int HALF_PERIOD = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

// ==== test/conv_line_tb.sv ====
module conv_line_tb;

    localparam int FIRST_WIDTH  = 5;
    localparam int FIRST_ROWS   = 6;
    localparam int SECOND_WIDTH = 64;
    localparam int SECOND_ROWS  = 5;
    localparam int MODEL_ROWS   = 8;
    localparam int TOTAL_PIX    = FIRST_WIDTH * FIRST_ROWS + SECOND_WIDTH * SECOND_ROWS;
    localparam int CYCLE_LIMIT  = 8 * TOTAL_PIX + 200;

    logic                    clk;
    logic                    rst;
    line_buf_pkg::col_addr_t row_width;
    line_buf_pkg::pixel_t    pixel_in;
    logic                    pixel_valid;
    logic                    full;
    line_buf_pkg::sum_t      sum_out;
    logic                    sum_valid;

    // Every row written in the current phase
    line_buf_pkg::pixel_t rows [MODEL_ROWS][line_buf_pkg::MAX_ROW];

    // Expected sums in output order
    int          exp_q [$];
    logic [31:0] rng;
    int          cur_width;
    int          rows_done;

    // Monitor state
    logic full_q;
    logic full_prev;
    int   rises;
    int   pass_sums;
    int   high_cnt;
    int   cycle_cnt;

    tb_clock u_clock (
        .clk (clk)
    );

    conv_line_top UUT (
        .clk         (clk),
        .rst         (rst),
        .row_width   (row_width),
        .pixel_in    (pixel_in),
        .pixel_valid (pixel_valid),
        .full        (full),
        .sum_out     (sum_out),
        .sum_valid   (sum_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Nine pixels of rows top..top+2 and columns c-2..c
    function automatic int window_sum(input int top, input int c);
        int s;
        s = 0;
        for (int r = top; r < top + 3; r++) begin
            for (int k = c - 2; k <= c; k++) begin
                s = s + int'(rows[r][k]);
            end
        end
        return s;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("test failed");
        $fatal(1, "Stopped at the first wrong value");
    endtask

    task automatic report_failure(input string msg);
        $display("Failure at time %0t: %s", $time, msg);
        $display("test failed");
        $fatal(1, "Stopped at the first protocol failure");
    endtask

    task automatic apply_reset(input int width);
        @(posedge clk);
        rst       <= 1'b1;
        row_width <= line_buf_pkg::col_addr_t'(width);
        cur_width = width;
        rows_done = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic feed_row(input int width, input int idx);
        int col;
        col = 0;
        while (col < width) begin
            @(posedge clk);
            rng = xorshift32(rng);
            // Hold off while full, and leave random gaps
            if (full_q || rng[1:0] == 2'b00) begin
                pixel_valid <= 1'b0;
            end else begin
                pixel_in    <= rng[15:8];
                pixel_valid <= 1'b1;
                rows[idx][col] = rng[15:8];
                col = col + 1;
            end
        end
        rows_done = rows_done + 1;
        // Third row onwards starts a pass over the last three rows
        if (idx >= 2) begin
            for (int c = 2; c < width; c++) begin
                exp_q.push_back(window_sum(idx - 2, c));
            end
        end
        // Idle edge so that full shows the completed row
        @(posedge clk);
        pixel_valid <= 1'b0;
    endtask

    task automatic run_phase(input int width, input int nrows);
        for (int n = 0; n < nrows; n++) begin
            feed_row(width, n);
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (6) @(posedge clk);
        assert (rises == nrows - 2)
            else report_mismatch($sformatf("%0d passes, expected %0d", rises, nrows - 2));
        assert (pass_sums == width - 2)
            else report_mismatch($sformatf("last pass gave %0d sums, expected %0d",
                                           pass_sums, width - 2));
    endtask

    // Outputs sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin : monitor
        int expected;
        full_q = (full === 1'b1);
        if (rst !== 1'b0) begin
            full_prev = 1'b0;
            rises     = 0;
            pass_sums = 0;
            high_cnt  = 0;
        end else begin
            if (rows_done < 3) begin
                assert (full === 1'b0 && sum_valid === 1'b0)
                    else report_failure("full or sum_valid high before three rows were written");
            end
            assert (!(pixel_valid && full_q))
                else report_failure("pixel strobed while full was high");

            // New pass begins
            if (full_q && !full_prev) begin
                assert (rows_done == rises + 3)
                    else report_failure("full rose without exactly one new row per pass");
                if (rises > 0) begin
                    assert (pass_sums == cur_width - 2)
                        else report_mismatch($sformatf("pass gave %0d sums, expected %0d",
                                                       pass_sums, cur_width - 2));
                end
                rises     = rises + 1;
                pass_sums = 0;
                high_cnt  = 0;
            end
            if (full_q) begin
                high_cnt = high_cnt + 1;
                assert (high_cnt <= cur_width + 3)
                    else report_failure("full stayed high longer than one pass");
            end

            if (sum_valid === 1'b1) begin
                assert (exp_q.size() > 0)
                    else report_failure("sum_valid high with no sum expected");
                expected = exp_q.pop_front();
                assert (sum_out === line_buf_pkg::sum_t'(expected))
                    else report_mismatch($sformatf("sum_out %0d, expected %0d",
                                                   sum_out, expected));
                pass_sums = pass_sums + 1;
            end
            full_prev = full_q;
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    initial begin
        rst          = 1'b1;
        row_width    = line_buf_pkg::col_addr_t'(FIRST_WIDTH);
        pixel_in     = '0;
        pixel_valid  = 1'b0;
        rng          = 32'd57664;
        cur_width    = FIRST_WIDTH;
        rows_done    = 0;
        cycle_cnt    = 0;

        apply_reset(FIRST_WIDTH);
        run_phase(FIRST_WIDTH, FIRST_ROWS);

        // Full width row, address wraps to 0
        apply_reset(SECOND_WIDTH);
        run_phase(SECOND_WIDTH, SECOND_ROWS);

        $display("test passed");
        $finish;
    end

endmodule

// ==== build.f ====
design/line_buf_pkg.sv
design/row_ram.sv
design/line_coupler.sv
design/read_sequencer.sv
design/window_shift.sv
design/box_filter.sv
design/conv_line_top.sv
test/tb_clock.sv
test/conv_line_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module conv_line_tb -o conv_line_sim

# Log is kept even when the run stops early
./obj_dir/conv_line_sim | tee sim.log

if grep -q "^test passed$" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
